// File: verilog.f
source/video_timing_pkg.sv
source/scan_code_pkg.sv
source/line_blank_tracker.sv
source/frame_blank_tracker.sv
source/crop_adjust.sv
source/screen_snapshot.sv
source/blank_crop_top.sv
dv/tb_clock_gen.sv
dv/blank_crop_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the blank and crop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f verilog.f --top-module blank_crop_tb -o blank_crop_sim > build.log 2>&1 \
	&& ./obj_dir/blank_crop_sim > sim.log 2>&1 \
	|| echo "Build or simulation ended with an error, see build.log and sim.log"

grep -qx "RESULT: PASS" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: dv/blank_crop_tb.sv
// Blank and crop unit testbench
`default_nettype none

module blank_crop_tb;

	import video_timing_pkg::*;
	import scan_code_pkg::*;

	localparam int NUM_ENTRIES  = 9;
	localparam int NUM_KEY_ONLY = 4;      // Entries 1 to 4 are shuffled
	localparam int LINES        = 30;
	localparam int LINE_CYCLES  = 64;
	localparam int FRAME_CYCLES = LINES * LINE_CYCLES;
	localparam int MAX_CYCLES   = NUM_ENTRIES * 3 * FRAME_CYCLES + 20000;

	typedef struct packed {
		logic [5:0][7:0] codes;           // First event in the top byte
		logic [2:0]      ncodes;
		logic [1:0]      kind;
		logic            use_preset;
		crop_offsets_t   preset;
		logic [1:0]      res;
		logic            geom;
		logic            check_width;
	} entry_t;

	logic          clk_sys;
	logic          reset;
	raster_in_t    raster;
	kbd_event_t    kbd;
	logic          preset_load;
	crop_offsets_t preset;
	logic          hde;
	logic          vde;
	screen_info_t  info;

	entry_t        table_mem [NUM_ENTRIES];
	int            order [NUM_ENTRIES];
	int            seed = 32'h5400_9912;
	int            cycles = 0;
	int            tests_passed = 0;
	int            tests_failed = 0;

	// Reference model state
	crop_offsets_t m_off;
	logic          m_alt;
	logic [1:0]    m_res;
	coord_t        m_h;
	coord_t        m_v;
	coord_t        prev_vsize;            // Height of the last frame sent
	logic [6:0]    m_count;

	tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(2)) tb_clock_gen_i (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	blank_crop_top #(.FORCE_MARGIN(FORCE_MARGIN)) blank_crop_top_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.raster      (raster),
		.kbd         (kbd),
		.preset_load (preset_load),
		.preset      (preset),
		.hde         (hde),
		.vde         (vde),
		.info        (info)
	);

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	// Geometry variants with hblank low from lo to hi and vblank on the first lines
	function automatic int hb_lo(input logic geom);
		return geom ? 16 : 12;
	endfunction

	function automatic int hb_hi(input logic geom);
		return geom ? 47 : 51;
	endfunction

	function automatic int vb_lines(input logic geom);
		return geom ? 8 : 6;
	endfunction

	function automatic crop_offsets_t make_offsets(input int l, input int r, input int t,
		input int b);
		crop_offsets_t o;
		o.hbl_l = coord_t'(l);
		o.hbl_r = coord_t'(r);
		o.vbl_t = coord_t'(t);
		o.vbl_b = coord_t'(b);
		return o;
	endfunction

	task automatic set_entry(input int idx, input logic [5:0][7:0] codes, input int n,
		input logic [1:0] kind, input logic use_preset, input crop_offsets_t pre,
		input logic [1:0] res, input logic geom, input logic check_width);
		table_mem[idx].codes       = codes;
		table_mem[idx].ncodes      = 3'(n);
		table_mem[idx].kind        = kind;
		table_mem[idx].use_preset  = use_preset;
		table_mem[idx].preset      = pre;
		table_mem[idx].res         = res;
		table_mem[idx].geom        = geom;
		table_mem[idx].check_width = check_width;
	endtask

	// Crop key rules
	task automatic model_key(input logic [7:0] code);
		case (code)
			KEY_CLEAR:                  m_off = '0;
			KEY_UP:
				if (m_alt) m_off.vbl_b += 12'd1;
				else       m_off.vbl_t += 12'd1;
			KEY_DOWN:
				if (m_alt) m_off.vbl_b -= 12'd1;
				else       m_off.vbl_t -= 12'd1;
			KEY_LEFT:
				if (m_alt) m_off.hbl_r += 12'd4;
				else       m_off.hbl_l += 12'd4;
			KEY_RIGHT:
				if (m_alt) m_off.hbl_r -= 12'd4;
				else       m_off.hbl_l -= 12'd4;
			KEY_ALT_L, KEY_ALT_R:       m_alt = 1'b1;
			KEY_ALT_L_UP, KEY_ALT_R_UP: m_alt = 1'b0;
			default: ;
		endcase
	endtask

	// Snapshot sees this frame's width and res, and the previous frame's height
	task automatic model_frame(input logic [1:0] res, input logic geom);
		coord_t cap_h;
		coord_t cap_v;
		cap_h = coord_t'(hb_hi(geom) - hb_lo(geom) + 1);
		cap_v = prev_vsize;
		if (res != m_res || cap_h != m_h || cap_v != m_v) m_count = m_count + 7'd1;
		m_res      = res;
		m_h        = cap_h;
		m_v        = cap_v;
		prev_vsize = coord_t'(LINES - vb_lines(geom));
	endtask

	task automatic apply_events(input entry_t e);
		int i;
		if (e.ncodes == 3'd0 && e.use_preset) begin
			@(negedge clk_sys);
			preset_load = 1'b1;
			preset      = e.preset;
			m_off       = e.preset;
			@(negedge clk_sys);
			preset_load = 1'b0;
		end
		for (i = 0; i < int'(e.ncodes); i++) begin
			@(negedge clk_sys);
			kbd.level = ~kbd.level;
			kbd.kind  = e.kind;
			kbd.code  = e.codes[5 - i];
			if (e.kind == KIND_KEY) model_key(e.codes[5 - i]);
			if (i == 0 && e.use_preset) begin   // Preset in the same cycle as a key
				preset_load = 1'b1;
				preset      = e.preset;
				m_off       = e.preset;
			end
			@(negedge clk_sys);
			preset_load = 1'b0;
		end
	endtask

	// One progressive frame that counts hde on line 15 and samples vde
	task automatic run_frame(input logic [1:0] res, input logic geom, input logic count_line,
		output int width, output logic vde_active, output logic vde_blank);
		int line;
		int p;
		width      = 0;
		vde_active = 1'b0;
		vde_blank  = 1'b1;
		raster.res = res;
		for (line = 0; line < LINES; line++) begin
			for (p = 0; p < LINE_CYCLES; p++) begin
				@(negedge clk_sys);
				if (count_line && line == 15 && hde) width++;
				if (line == 15 && p == 32) vde_active = vde;   // Mid active line
				if (line == 2 && p == 32)  vde_blank  = vde;   // Inside vsync
				raster.hs_n   = (p >= 4);
				raster.hblank = (p < hb_lo(geom)) || (p > hb_hi(geom));
				raster.vblank = (line < vb_lines(geom));
				raster.vs_n   = !(line == 1 || line == 2);
			end
		end
	endtask

	task automatic compare_field(input int entry, input string what, input int got,
		input int expected, inout int errs);
		if (got != expected) begin
			$display("Fail at %0t: entry %0d %s got %0d expected %0d",
				$time, entry, what, got, expected);
			errs++;
		end
	endtask

	task automatic run_entry(input int idx);
		entry_t e;
		int     f;
		int     width;
		int     exp_w;
		int     errs;
		logic   vde_act;
		logic   vde_blk;
		e    = table_mem[idx];
		errs = 0;
		apply_events(e);
		for (f = 0; f < 3; f++) begin
			run_frame(e.res, e.geom, f == 2, width, vde_act, vde_blk);
			model_frame(e.res, e.geom);
		end
		@(negedge clk_sys);
		compare_field(idx, "hbl_l", int'(info.offsets.hbl_l), int'(m_off.hbl_l), errs);
		compare_field(idx, "hbl_r", int'(info.offsets.hbl_r), int'(m_off.hbl_r), errs);
		compare_field(idx, "vbl_t", int'(info.offsets.vbl_t), int'(m_off.vbl_t), errs);
		compare_field(idx, "vbl_b", int'(info.offsets.vbl_b), int'(m_off.vbl_b), errs);
		compare_field(idx, "hsize", int'(info.hsize), int'(m_h), errs);
		compare_field(idx, "vsize", int'(info.vsize), int'(m_v), errs);
		compare_field(idx, "res", int'(info.res), int'(m_res), errs);
		compare_field(idx, "change_count", int'(info.change_count), int'(m_count), errs);
		compare_field(idx, "vde active line", int'(vde_act), 1, errs);
		compare_field(idx, "vde blank line", int'(vde_blk), 0, errs);
		if (e.check_width) begin
			exp_w = hb_hi(e.geom) - hb_lo(e.geom) + 1 + int'($signed(m_off.hbl_r))
				- int'($signed(m_off.hbl_l));
			compare_field(idx, "hde width", width, exp_w, errs);
		end
		if (errs == 0) begin
			$display("Entry %0d pass at %0t", idx, $time);
			tests_passed++;
		end else begin
			tests_failed++;
		end
	endtask

	initial begin
		int   i;
		int   j;
		int   tmp;
		int   width;
		int   errs;
		logic vde_act;
		logic vde_blk;
		raster.hs_n   = 1'b1;
		raster.vs_n   = 1'b1;
		raster.hblank = 1'b1;
		raster.vblank = 1'b1;
		raster.field1 = 1'b0;
		raster.lace   = 1'b0;
		raster.res    = 2'd0;
		kbd           = '0;
		preset_load   = 1'b0;
		preset        = '0;
		errs          = 0;
		wait (!reset);

		// Two frames to settle the measurements
		run_frame(2'd0, 1'b0, 1'b0, width, vde_act, vde_blk);
		run_frame(2'd0, 1'b0, 1'b0, width, vde_act, vde_blk);
		@(negedge clk_sys);
		compare_field(-1, "hsize", int'(info.hsize), 40, errs);
		compare_field(-1, "vsize", int'(info.vsize), 24, errs);
		// Width then height differ from the cleared snapshot
		compare_field(-1, "change_count", int'(info.change_count), 2, errs);
		if (errs == 0) begin
			$display("Warm-up measurement pass at %0t", $time);
			tests_passed++;
		end else begin
			tests_failed++;
		end
		m_off      = '0;
		m_alt      = 1'b0;
		m_res      = 2'd0;
		m_h        = 12'd40;
		m_v        = 12'd24;
		prev_vsize = 12'd24;
		m_count    = 7'd2;

		set_entry(0, '0, 0, KIND_KEY, 1'b1, make_offsets(12, 0, 0, 0), 2'd0, 1'b0, 1'b1);
		set_entry(1, {KEY_LEFT, KEY_LEFT, 32'h0}, 2, KIND_KEY, 1'b0, '0, 2'd0, 1'b0, 1'b1);
		set_entry(2, {KEY_ALT_L, KEY_LEFT, KEY_ALT_L_UP, KEY_UP, KEY_UP, 8'h0}, 5, KIND_KEY,
			1'b0, '0, 2'd0, 1'b0, 1'b1);
		set_entry(3, {KEY_RIGHT, KEY_DOWN, 32'h0}, 2, KIND_KEY, 1'b0, '0, 2'd0, 1'b0, 1'b1);
		set_entry(4, {KEY_ALT_R, KEY_DOWN, KEY_RIGHT, KEY_ALT_R_UP, 16'h0}, 4, KIND_KEY,
			1'b0, '0, 2'd0, 1'b0, 1'b1);
		set_entry(5, {KEY_CLEAR, 40'h0}, 1, KIND_KEY, 1'b0, '0, 2'd1, 1'b0, 1'b0);
		set_entry(6, {KEY_LEFT, 40'h0}, 1, KIND_KEY, 1'b1, make_offsets(4, 0, 1, 'hFFE),
			2'd1, 1'b1, 1'b1);
		set_entry(7, {KEY_LEFT, KEY_UP, 32'h0}, 2, 2'd1, 1'b0, '0, 2'd1, 1'b1, 1'b1);
		set_entry(8, '0, 0, KIND_KEY, 1'b0, '0, 2'd0, 1'b0, 1'b1);

		for (i = 0; i < NUM_ENTRIES; i++) order[i] = i;
		for (i = 1; i < NUM_KEY_ONLY; i++) begin
			tmp      = $random(seed);
			j        = i + ((tmp & 32'h7fff_ffff) % (NUM_KEY_ONLY + 1 - i));
			tmp      = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end

		for (i = 0; i < NUM_ENTRIES; i++) run_entry(order[i]);

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
// Testbench clock and reset
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 100,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

`default_nettype wire

// File: source/blank_crop_top.sv
// Video blanking and crop unit
`default_nettype none

module blank_crop_top #(
	parameter int FORCE_MARGIN = video_timing_pkg::FORCE_MARGIN
) (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire video_timing_pkg::raster_in_t    raster,
	input  wire scan_code_pkg::kbd_event_t       kbd,
	input  wire                            preset_load,
	input  wire video_timing_pkg::crop_offsets_t preset,
	output logic                           hde,
	output logic                           vde,
	output video_timing_pkg::screen_info_t info
);

	import video_timing_pkg::*;

	crop_offsets_t offsets;
	coord_t        hsize;
	coord_t        vsize;
	coord_t        frame_line;
	logic          line_blank;
	logic          frame_start;

	// Operator and host crop control
	crop_adjust crop_adjust_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.kbd         (kbd),
		.preset_load (preset_load),
		.preset      (preset),
		.offsets     (offsets)
	);

	line_blank_tracker #(
		.FORCE_MARGIN (FORCE_MARGIN)
	) line_blank_tracker_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.raster     (raster),
		.offsets    (offsets),
		.frame_line (frame_line),
		.hde        (hde),
		.line_blank (line_blank),
		.hsize      (hsize)
	);

	frame_blank_tracker frame_blank_tracker_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.raster      (raster),
		.offsets     (offsets),
		.line_blank  (line_blank),
		.vde         (vde),
		.vsize       (vsize),
		.frame_line  (frame_line),
		.frame_start (frame_start)
	);

	screen_snapshot screen_snapshot_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.frame_start (frame_start),
		.offsets     (offsets),
		.hsize       (hsize),
		.vsize       (vsize),
		.res         (raster.res),
		.info        (info)
	);

endmodule

`default_nettype wire

// File: source/screen_snapshot.sv
// Per-frame screen information
`default_nettype none

module screen_snapshot (
	input  wire                                  clk_sys,
	input  wire                                  reset,
	input  wire                                  frame_start,
	input  wire video_timing_pkg::crop_offsets_t offsets,
	input  wire video_timing_pkg::coord_t        hsize,
	input  wire video_timing_pkg::coord_t        vsize,
	input  wire [1:0]                            res,
	output video_timing_pkg::screen_info_t       info
);

	import video_timing_pkg::*;

	logic geometry_changed;

	// Compare against what the host last saw
	assign geometry_changed = (info.res != res) ||
		(info.hsize != hsize) ||
		(info.vsize != vsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			info <= '0;
		end else if (frame_start) begin
			info.offsets <= offsets;
			info.hsize   <= hsize;
			info.vsize   <= vsize;
			info.res     <= res;
			if (geometry_changed) begin
				info.change_count <= info.change_count + 7'd1;   // Wraps at 7 bits
			end
		end
	end

endmodule

`default_nettype wire

// File: source/crop_adjust.sv
// Crop offset registers
`default_nettype none

module crop_adjust (
	input  wire                                  clk_sys,
	input  wire                                  reset,
	input  wire scan_code_pkg::kbd_event_t       kbd,
	input  wire                                  preset_load,
	input  wire video_timing_pkg::crop_offsets_t preset,
	output video_timing_pkg::crop_offsets_t      offsets
);

	import video_timing_pkg::*;
	import scan_code_pkg::*;

	logic level_d;
	logic key_event;
	logic alt;              // Either alt key held

	// New event on every level toggle
	assign key_event = (level_d ^ kbd.level) && (kbd.kind == KIND_KEY);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			level_d <= 1'b0;
			alt     <= 1'b0;
			offsets <= '0;
		end else begin
			level_d <= kbd.level;

			if (key_event) begin
				case (kbd.code)
					KEY_CLEAR: begin
						offsets <= '0;
					end
					KEY_UP: begin
						if (alt) offsets.vbl_b <= offsets.vbl_b + 12'd1;
						else     offsets.vbl_t <= offsets.vbl_t + 12'd1;
					end
					KEY_DOWN: begin
						if (alt) offsets.vbl_b <= offsets.vbl_b - 12'd1;
						else     offsets.vbl_t <= offsets.vbl_t - 12'd1;
					end
					KEY_LEFT: begin
						if (alt) offsets.hbl_r <= offsets.hbl_r + H_STEP;
						else     offsets.hbl_l <= offsets.hbl_l + H_STEP;
					end
					KEY_RIGHT: begin
						if (alt) offsets.hbl_r <= offsets.hbl_r - H_STEP;
						else     offsets.hbl_l <= offsets.hbl_l - H_STEP;
					end
					KEY_ALT_L, KEY_ALT_R: begin
						alt <= 1'b1;
					end
					KEY_ALT_L_UP, KEY_ALT_R_UP: begin
						alt <= 1'b0;
					end
					default: begin
					end
				endcase
			end

			// Host preset overrides any key in the same cycle
			if (preset_load) offsets <= preset;
		end
	end

endmodule

`default_nettype wire

// File: source/frame_blank_tracker.sv
// Vertical blank and crop tracker
`default_nettype none

module frame_blank_tracker (
	input  wire                                  clk_sys,
	input  wire                                  reset,
	input  wire video_timing_pkg::raster_in_t    raster,
	input  wire video_timing_pkg::crop_offsets_t offsets,
	input  wire                                  line_blank,
	output logic                                 vde,
	output video_timing_pkg::coord_t             vsize,
	output video_timing_pkg::coord_t             frame_line,
	output logic                                 frame_start
);

	import video_timing_pkg::*;

	logic   vblank;         // Core vblank merged with vsync
	logic   vblank_d;
	logic   vs_d;
	logic   hs_d;
	logic   lbl_d;
	logic   vblank_rise;
	logic   vblank_fall;
	logic   vs_rise;
	logic   line_start;
	logic   measure;        // Progressive or first field
	coord_t vcnt;
	coord_t vend;           // Line where vblank falls
	coord_t vmax;           // Frame height
	coord_t vs_end;
	coord_t f1_vend;
	coord_t f1_vsize;       // Active lines of field 1
	coord_t bottom_line;
	logic   svbl;
	logic   fvbl;
	logic   svbl_nxt;
	logic   fvbl_nxt;

	assign vblank      = raster.vblank | ~raster.vs_n;
	assign vblank_rise = ~vblank_d & vblank;
	assign vblank_fall = vblank_d & ~vblank;
	assign vs_rise     = ~vs_d & raster.vs_n;
	assign measure     = ~raster.lace | ~raster.field1;
	assign frame_start = vblank_fall;
	assign frame_line  = vcnt;

	// Bit 11 set means a negative offset from the frame end
	assign bottom_line = offsets.vbl_b[11] ? vmax + offsets.vbl_b : offsets.vbl_b;

	// Vertical blanks move only at the end of a line blank
	assign line_start = (lbl_d & ~line_blank) | (vcnt == '0);

	always_comb begin
		svbl_nxt = svbl;
		fvbl_nxt = fvbl;
		if (line_start) begin
			if (vcnt == vend + offsets.vbl_t) svbl_nxt = 1'b0;
			if (vcnt == bottom_line)          svbl_nxt = 1'b1;
			if (vcnt == vmax - 12'd1)         fvbl_nxt = 1'b1;
			if (vcnt == vs_end + 12'd2)       fvbl_nxt = 1'b0;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			vblank_d <= 1'b1;
			vs_d     <= 1'b1;
			hs_d     <= 1'b1;
			lbl_d    <= 1'b1;
			vcnt     <= '0;
			vend     <= '0;
			vmax     <= '0;
			vs_end   <= '0;
			f1_vend  <= '0;
			f1_vsize <= '0;
			vsize    <= '0;
			svbl     <= 1'b1;
			fvbl     <= 1'b1;
			vde      <= 1'b0;
		end else begin
			vblank_d <= vblank;
			vs_d     <= raster.vs_n;
			hs_d     <= raster.hs_n;
			lbl_d    <= line_blank;

			if (hs_d && !raster.hs_n) vcnt <= vcnt + 12'd1;
			if (vblank_rise)          vcnt <= '0;

			if (measure) begin
				if (vblank_fall) vend   <= vcnt;
				if (vs_rise)     vs_end <= vcnt;
				if (vblank_rise) begin
					vmax     <= vcnt;
					vsize    <= vcnt - vend + f1_vsize;   // Field 1 folded in here
					f1_vsize <= '0;
				end
			end else begin
				if (vblank_fall) f1_vend  <= vcnt;
				if (vblank_rise) f1_vsize <= vcnt - f1_vend;
			end

			svbl <= svbl_nxt;
			fvbl <= fvbl_nxt;
			vde  <= ~(svbl_nxt | fvbl_nxt);
		end
	end

endmodule

`default_nettype wire

// File: source/line_blank_tracker.sv
// Horizontal blank and crop tracker
`default_nettype none

module line_blank_tracker #(
	parameter int FORCE_MARGIN = video_timing_pkg::FORCE_MARGIN
) (
	input  wire                                  clk_sys,
	input  wire                                  reset,
	input  wire video_timing_pkg::raster_in_t    raster,
	input  wire video_timing_pkg::crop_offsets_t offsets,
	input  wire video_timing_pkg::coord_t        frame_line,
	output logic                                 hde,
	output logic                                 line_blank,
	output video_timing_pkg::coord_t             hsize
);

	import video_timing_pkg::*;

	logic   hs_d;
	logic   hblank_d;
	logic   hs_fall;
	logic   hblank_fall;
	logic   hblank_rise;
	coord_t hcnt;           // Pixel position within the line
	coord_t hend;           // Where hblank falls
	coord_t hsta;           // Where hblank rises
	coord_t hmax;           // Line length
	coord_t soft_open;
	coord_t soft_close;
	coord_t force_close;
	logic   shbl;           // Soft blank from crop offsets
	logic   fhbl;           // Forced blank at the line edges

	assign hs_fall     = hs_d & ~raster.hs_n;
	assign hblank_fall = hblank_d & ~raster.hblank;
	assign hblank_rise = ~hblank_d & raster.hblank;

	// Window edges from the previous line's measurements
	assign soft_open   = hend + offsets.hbl_l - 12'd2;
	assign soft_close  = hsta + offsets.hbl_r - 12'd2;
	assign force_close = hmax - coord_t'(FORCE_MARGIN);

	assign line_blank = shbl | fhbl | ~raster.hs_n;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hs_d     <= 1'b1;
			hblank_d <= 1'b1;
			hcnt     <= '0;
			hend     <= '0;
			hsta     <= '0;
			hmax     <= '0;
			shbl     <= 1'b1;
			fhbl     <= 1'b1;
			hsize    <= '0;
			hde      <= 1'b0;
		end else begin
			hs_d     <= raster.hs_n;
			hblank_d <= raster.hblank;

			if (!raster.hs_n) begin
				hcnt <= '0;     // Held at zero through sync
			end else begin
				hcnt <= hcnt + 12'd1;
			end

			if (hblank_fall) hend <= hcnt;
			if (hblank_rise) hsta <= hcnt;
			if (hs_fall)     hmax <= hcnt;

			if (hcnt == soft_open)  shbl <= 1'b0;
			if (hcnt == soft_close) shbl <= 1'b1;

			if (hcnt == coord_t'(FORCE_MARGIN)) fhbl <= 1'b0;
			if (hcnt == force_close)            fhbl <= 1'b1;

			// Active width sampled once per frame
			if (hblank_rise && !raster.field1 && frame_line == 12'd1) begin
				hsize <= hcnt - hend;
			end

			hde <= ~line_blank;
		end
	end

endmodule

`default_nettype wire

// File: source/scan_code_pkg.sv
// Keyboard event types and scan codes
`default_nettype none

package scan_code_pkg;

	// One keyboard or mouse event, level toggles once per event
	typedef struct packed {
		logic       level;
		logic [1:0] kind;
		logic [7:0] code;
	} kbd_event_t;

	// Event kind carrying a key scan code
	localparam logic [1:0] KIND_KEY = 2'd3;

	// Adjust keys
	localparam logic [7:0] KEY_CLEAR    = 8'h41;   // Backspace
	localparam logic [7:0] KEY_UP       = 8'h4c;
	localparam logic [7:0] KEY_DOWN     = 8'h4d;
	localparam logic [7:0] KEY_RIGHT    = 8'h4e;
	localparam logic [7:0] KEY_LEFT     = 8'h4f;

	// Alt press and release
	localparam logic [7:0] KEY_ALT_L    = 8'h64;
	localparam logic [7:0] KEY_ALT_R    = 8'h65;
	localparam logic [7:0] KEY_ALT_L_UP = 8'hE4;
	localparam logic [7:0] KEY_ALT_R_UP = 8'hE5;

	// Pixels per horizontal key press
	localparam logic [11:0] H_STEP = 12'd4;

endpackage

`default_nettype wire

// File: source/video_timing_pkg.sv
// Raster geometry types
`default_nettype none

package video_timing_pkg;

	// Pixel or line position
	typedef logic [11:0] coord_t;

	// Default width of the forced blank at each line edge
	localparam int FORCE_MARGIN = 8;

	// Video status from the core, syncs active low
	typedef struct packed {
		logic       hs_n;
		logic       vs_n;
		logic       hblank;
		logic       vblank;
		logic       field1;     // Second field of an interlaced frame
		logic       lace;       // Interlace mode
		logic [1:0] res;
	} raster_in_t;

	typedef struct packed {
		coord_t hbl_l;          // Left crop, pixels
		coord_t hbl_r;          // Right edge shift, pixels
		coord_t vbl_t;          // Top crop, lines
		coord_t vbl_b;          // Bottom edge, bit 11 counts back from frame end
	} crop_offsets_t;

	// Per-frame screen information seen by the host
	typedef struct packed {
		crop_offsets_t offsets;
		coord_t        hsize;
		coord_t        vsize;
		logic [1:0]    res;
		logic [6:0]    change_count;
	} screen_info_t;

endpackage

`default_nettype wire
